// File: exec_stage.f
+incdir+.
exec_pkg.sv
exec_result_if.sv
operand_forward.sv
alu_unit.sv
serial_divider.sv
exec_control.sv
exec_stage.sv
tb_exec_stage.sv

// File: tb_exec_stage.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module tb_exec_stage;
	import exec_pkg::*;

	localparam int MODE_RAND = 0;
	localparam int MODE_SAME = 1;
	localparam int MODE_ZERO = 2;
	localparam int WAIT_LIMIT = 100;

	typedef struct {
		exec_unit_t unit;
		alu_op_t op;
		logic [`EXEC_PTR_W-1:0] p0;
		logic [`EXEC_PTR_W-1:0] p1;
		logic imm;
		logic [`EXEC_PTR_W-1:0] dest;
		logic wb;
		logic fwb;
		int mode;
	} row_t;

	logic iCLOCK = 1'b0;
	logic inRESET;
	logic flush;
	logic stall;
	logic prev_valid;
	logic prev_lock;
	exec_unit_t prev_unit;
	exec_cmd_u prev_cmd;
	logic [`EXEC_PTR_W-1:0] prev_destination;
	logic prev_writeback;
	logic prev_flags_writeback;
	logic [`EXEC_DATA_W-1:0] prev_source0;
	logic [`EXEC_DATA_W-1:0] prev_source1;
	logic [`EXEC_PTR_W-1:0] prev_source0_pointer;
	logic [`EXEC_PTR_W-1:0] prev_source1_pointer;
	logic prev_source1_imm;
	logic mem_req;
	logic mem_busy;
	logic mem_rw;
	exec_order_t mem_order;
	logic [`EXEC_DATA_W-1:0] mem_addr;
	logic [`EXEC_DATA_W-1:0] mem_wdata;
	logic mem_ack;
	logic [`EXEC_DATA_W-1:0] mem_rdata;
	logic next_valid;
	logic [`EXEC_DATA_W-1:0] next_data;
	logic [`EXEC_PTR_W-1:0] next_destination;
	logic next_writeback;
	exec_flags_t flags;

	integer seed = 32'h7b4f886c;
	int errors = 0;
	int checks = 0;
	row_t rows[$];
	logic [31:0] mem_words [16];
	logic [31:0] ref_words [16];

	// Reference copy of the result register and the history entry
	logic res_v;
	logic [31:0] res_d;
	logic [4:0] res_dst;
	logic res_wb;
	logic hist_v;
	logic [31:0] hist_d;
	logic [4:0] hist_dst;
	logic hist_wb;
	exec_flags_t flags_model;

	always #4 iCLOCK = ~iCLOCK;

	exec_stage UUT (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.stall(stall),
		.prev_valid(prev_valid),
		.prev_lock(prev_lock),
		.prev_unit(prev_unit),
		.prev_cmd(prev_cmd),
		.prev_destination(prev_destination),
		.prev_writeback(prev_writeback),
		.prev_flags_writeback(prev_flags_writeback),
		.prev_source0(prev_source0),
		.prev_source1(prev_source1),
		.prev_source0_pointer(prev_source0_pointer),
		.prev_source1_pointer(prev_source1_pointer),
		.prev_source1_imm(prev_source1_imm),
		.mem_req(mem_req),
		.mem_busy(mem_busy),
		.mem_rw(mem_rw),
		.mem_order(mem_order),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.next_valid(next_valid),
		.next_data(next_data),
		.next_destination(next_destination),
		.next_writeback(next_writeback),
		.flags(flags)
	);

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error: %s expected %h got %h at %0t", name, exp, got, $time);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Gave up waiting for %s at %0t", what, $time);
	endtask

	function automatic row_t make_row(exec_unit_t unit, alu_op_t op, logic [4:0] p0,
			logic [4:0] p1, logic imm, logic [4:0] dest, logic wb, logic fwb, int mode);
		row_t r;
		r.unit = unit;
		r.op = op;
		r.p0 = p0;
		r.p1 = p1;
		r.imm = imm;
		r.dest = dest;
		r.wb = wb;
		r.fwb = fwb;
		r.mode = mode;
		return r;
	endfunction

	function automatic logic [31:0] second_operand(int mode, logic [31:0] a);
		if (mode == MODE_SAME) begin
			return a;
		end else if (mode == MODE_ZERO) begin
			return '0;
		end
		return $random(seed);
	endfunction

	function automatic logic [31:0] forward_value(logic [4:0] ptr, logic [31:0] supplied);
		if (res_v && res_wb && res_dst == ptr) begin
			return res_d;
		end else if (hist_v && hist_wb && hist_dst == ptr) begin
			return hist_d;
		end
		return supplied;
	endfunction

	task automatic shift_model(input logic v, input logic [31:0] d, input logic [4:0] dst,
			input logic wb);
		if (res_v) begin
			hist_v = 1'b1;
			hist_d = res_d;
			hist_dst = res_dst;
			hist_wb = res_wb;
		end
		res_v = v;
		res_d = d;
		res_dst = dst;
		res_wb = wb;
	endtask

	task automatic tick(input logic v, input logic [31:0] d, input logic [4:0] dst,
			input logic wb);
		@(negedge iCLOCK);
		shift_model(v, d, dst, wb);
	endtask

	task automatic idle_cycle();
		tick(1'b0, '0, '0, 1'b0);
	endtask

	task automatic clear_model();
		res_v = 1'b0;
		hist_v = 1'b0;
		flags_model = '0;
	endtask

	task automatic alu_reference(input exec_unit_t unit, input alu_op_t op, input logic [31:0] a,
			input logic [31:0] b, output logic [31:0] d, output exec_flags_t f);
		logic [32:0] sum;
		logic signed [32:0] ssum;
		logic [63:0] p;
		int sh;
		logic c;
		logic o;
		sh = b[4:0];
		c = 1'b0;
		o = 1'b0;
		d = '0;
		case (unit)
			UNIT_LOGIC: begin
				case (op)
					OP_BUF1: d = b;
					OP_AND: d = a & b;
					OP_OR: d = a | b;
					OP_XOR: d = a ^ b;
					default: d = ~a;
				endcase
			end
			UNIT_SHIFT: begin
				case (op)
					OP_SLL: d = a << sh;
					OP_SRL: d = a >> sh;
					OP_SRA: d = $signed(a) >>> sh;
					OP_ROL: d = (a << sh) | (a >> (32 - sh));
					default: d = (a >> sh) | (a << (32 - sh));
				endcase
				// Left shifts lose the top bits, right shifts the bottom ones
				if (sh != 0) begin
					c = (op == OP_SLL || op == OP_ROL) ? a[32 - sh] : a[sh - 1];
				end
			end
			UNIT_ADDER: begin
				if (op == OP_SUB) begin
					sum = {1'b0, a} - {1'b0, b};
					ssum = $signed({a[31], a}) - $signed({b[31], b});
				end else begin
					sum = {1'b0, a} + {1'b0, b};
					ssum = $signed({a[31], a}) + $signed({b[31], b});
				end
				d = sum[31:0];
				c = sum[32];
				o = ssum[32] != ssum[31];
			end
			default: begin
				p = {32'd0, a} * {32'd0, b};
				if (op == OP_MULH) begin
					d = p[63:32];
				end else begin
					d = p[31:0];
					c = p[32];
					o = d[31] ^ c;
				end
			end
		endcase
		f.sf = d[31];
		f.of = o;
		f.cf = c;
		f.pf = d[0];
		f.zf = (d == '0);
	endtask

	function automatic logic [31:0] div_reference(alu_op_t op, logic [31:0] a, logic [31:0] b);
		logic sgn;
		logic [31:0] ma;
		logic [31:0] mb;
		logic [31:0] q;
		logic [31:0] m;
		sgn = (op == OP_SDIV || op == OP_SMOD);
		if (b == '0) begin
			q = '1;
			m = a;
		end else begin
			ma = (sgn && a[31]) ? -a : a;
			mb = (sgn && b[31]) ? -b : b;
			q = ma / mb;
			m = ma % mb;
			if (sgn && (a[31] ^ b[31])) q = -q;
			if (sgn && a[31]) m = -m;
		end
		return (op == OP_UMOD || op == OP_SMOD) ? m : q;
	endfunction

	function automatic logic [31:0] extract(logic [31:0] word, logic [1:0] off, exec_order_t order);
		logic [31:0] lane;
		lane = word >> (8 * off);
		if (order == ORDER_BYTE) return lane & 32'h0000_00ff;
		if (order == ORDER_HALF) return lane & 32'h0000_ffff;
		return lane;
	endfunction

	task automatic drive_row(input row_t r, input logic [31:0] a, input logic [31:0] b);
		prev_unit = r.unit;
		prev_cmd.op = r.op;
		prev_source0 = a;
		prev_source1 = b;
		prev_source0_pointer = r.p0;
		prev_source1_pointer = r.p1;
		prev_source1_imm = r.imm;
		prev_destination = r.dest;
		prev_writeback = r.wb;
		prev_flags_writeback = r.fwb;
		prev_valid = 1'b1;
	endtask

	task automatic run_alu_row(input row_t r);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] s0;
		logic [31:0] s1;
		logic [31:0] d;
		exec_flags_t f;
		a = $random(seed);
		b = second_operand(r.mode, a);
		s0 = forward_value(r.p0, a);
		s1 = r.imm ? b : forward_value(r.p1, b);
		alu_reference(r.unit, r.op, s0, s1, d, f);
		drive_row(r, a, b);
		tick(1'b1, d, r.dest, r.wb);
		if (r.fwb && r.unit != UNIT_LOGIC) flags_model = f;
		compare("next_valid", next_valid, 1'b1);
		compare("next_data", next_data, d);
		compare("next_destination", next_destination, r.dest);
		compare("next_writeback", next_writeback, r.wb);
		compare("flags", flags, flags_model);
		prev_valid = 1'b0;
	endtask

	task automatic divide_and_wait(input row_t r);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] q;
		int waited;
		a = $random(seed);
		b = second_operand(r.mode, a);
		q = div_reference(r.op, forward_value(r.p0, a), r.imm ? b : forward_value(r.p1, b));
		drive_row(r, a, b);
		idle_cycle();
		prev_valid = 1'b0;
		waited = 0;
		while (!next_valid && waited < WAIT_LIMIT) begin
			compare("prev_lock", prev_lock, 1'b1);
			@(negedge iCLOCK);
			shift_model(next_valid, q, r.dest, r.wb);
			waited++;
		end
		if (!next_valid) begin
			report_timeout("the divide result");
		end else begin
			compare("next_data", next_data, q);
			compare("next_destination", next_destination, r.dest);
			compare("prev_lock", prev_lock, 1'b0);
			compare("flags", flags, flags_model);
		end
	endtask

	task automatic serve_memory(input logic is_store, input logic [31:0] exp_addr,
			input logic [31:0] exp_wdata, input exec_order_t exp_order);
		int n;
		int waited;
		waited = 0;
		while (!mem_req && waited < WAIT_LIMIT) begin
			idle_cycle();
			waited++;
		end
		if (!mem_req) report_timeout("the memory request");
		compare("mem_addr", mem_addr, exp_addr);
		compare("mem_rw", mem_rw, is_store);
		compare("mem_order", mem_order, exp_order);
		if (is_store) compare("mem_wdata", mem_wdata, exp_wdata);
		n = $random(seed) & 3;
		repeat (n) begin
			mem_busy = 1'b1;
			idle_cycle();
			compare("mem_req", mem_req, 1'b1);
		end
		mem_busy = 1'b0;
		idle_cycle();
		compare("mem_req", mem_req, 1'b0);
		n = $random(seed) & 3;
		repeat (n) begin
			idle_cycle();
			compare("prev_lock", prev_lock, 1'b1);
			compare("next_valid", next_valid, 1'b0);
		end
		mem_ack = 1'b1;
		if (is_store) begin
			mem_words[mem_addr[5:2]] = mem_wdata;
		end else begin
			mem_rdata = mem_words[mem_addr[5:2]];
		end
	endtask

	task automatic access_memory(input logic rw, input exec_order_t order, input logic [31:0] addr,
			input logic [4:0] dest);
		logic [31:0] a;
		logic [31:0] s0;
		logic [31:0] s1;
		logic [31:0] wdata;
		logic [31:0] expect_load;
		a = $random(seed);
		s0 = forward_value(5'd29, a);
		s1 = forward_value(5'd31, addr);
		wdata = s0 << (8 * s1[1:0]);
		if (rw) ref_words[s1[5:2]] = wdata;
		expect_load = extract(ref_words[s1[5:2]], s1[1:0], order);
		drive_row(make_row(UNIT_LDST, OP_BUF1, 29, 31, 0, dest, !rw, 0, MODE_RAND), a, addr);
		prev_cmd.mem.rw = rw;
		prev_cmd.mem.order = order;
		prev_cmd.mem.spare = '0;
		idle_cycle();
		prev_valid = 1'b0;
		serve_memory(rw, {s1[31:2], 2'b00}, wdata, order);
		if (rw) begin
			idle_cycle();
			compare("next_valid", next_valid, 1'b0);
		end else begin
			tick(1'b1, expect_load, dest, 1'b1);
			compare("next_valid", next_valid, 1'b1);
			compare("next_data", next_data, expect_load);
		end
		mem_ack = 1'b0;
		compare("prev_lock", prev_lock, 1'b0);
	endtask

	task automatic confirm_flushed();
		flush = 1'b1;
		idle_cycle();
		clear_model();
		flush = 1'b0;
		mem_busy = 1'b0;
		compare("prev_lock", prev_lock, 1'b0);
		compare("mem_req", mem_req, 1'b0);
		compare("flags", flags, 5'd0);
		repeat (40) begin
			idle_cycle();
			compare("next_valid", next_valid, 1'b0);
		end
	endtask

	initial begin
		logic [31:0] base;
		inRESET = 1'b0;
		flush = 1'b0;
		stall = 1'b0;
		mem_busy = 1'b0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		drive_row(make_row(UNIT_LOGIC, OP_BUF1, 0, 0, 0, 0, 0, 0, MODE_RAND), '0, '0);
		prev_cmd = '0;
		prev_valid = 1'b0;
		clear_model();
		for (int i = 0; i < 16; i++) begin
			mem_words[i] = 32'h9e37_79b9 * (i + 1);
			ref_words[i] = mem_words[i];
		end

		add_rows();
		repeat (2) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		idle_cycle();
		compare("next_valid", next_valid, 1'b0);
		compare("mem_req", mem_req, 1'b0);
		compare("prev_lock", prev_lock, 1'b0);
		compare("flags", flags, 5'd0);

		foreach (rows[i]) begin
			if (rows[i].unit == UNIT_DIV) begin
				divide_and_wait(rows[i]);
			end else begin
				run_alu_row(rows[i]);
			end
		end

		// Flags hold while stalled
		run_alu_row(make_row(UNIT_ADDER, OP_ADD, 1, 2, 0, 22, 1, 1, MODE_RAND));
		stall = 1'b1;
		drive_row(make_row(UNIT_ADDER, OP_SUB, 4, 4, 0, 23, 1, 1, MODE_SAME), 32'h5, 32'h5);
		#1;
		compare("next_valid", next_valid, 1'b0);
		idle_cycle();
		compare("next_valid", next_valid, 1'b0);
		compare("flags", flags, flags_model);
		stall = 1'b0;
		run_alu_row(make_row(UNIT_ADDER, OP_SUB, 4, 4, 0, 23, 1, 1, MODE_SAME));

		for (int off = 0; off < 4; off++) begin
			for (int o = 0; o < 3; o++) begin
				base = $random(seed);
				base[1:0] = off;
				access_memory(1'b1, exec_order_t'(o), base, 5'd28);
				access_memory(1'b0, exec_order_t'(o), base, 5'd28);
			end
		end

		// Divide aborted part way
		drive_row(make_row(UNIT_DIV, OP_SDIV, 1, 2, 0, 25, 1, 0, MODE_RAND), $random(seed),
			32'h0000_0007);
		idle_cycle();
		prev_valid = 1'b0;
		repeat (4) begin
			idle_cycle();
			compare("prev_lock", prev_lock, 1'b1);
		end
		confirm_flushed();
		run_alu_row(make_row(UNIT_ADDER, OP_ADD, 3, 4, 0, 10, 1, 1, MODE_RAND));

		// Load aborted while the memory is busy
		mem_busy = 1'b1;
		drive_row(make_row(UNIT_LDST, OP_BUF1, 29, 31, 0, 28, 1, 0, MODE_RAND), '0, 32'h40);
		prev_cmd.mem.order = ORDER_WORD;
		idle_cycle();
		prev_valid = 1'b0;
		compare("mem_req", mem_req, 1'b1);
		repeat (3) idle_cycle();
		confirm_flushed();
		run_alu_row(make_row(UNIT_MUL, OP_MULL, 10, 5, 0, 11, 1, 1, MODE_RAND));

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	task automatic add_rows();
		rows.push_back(make_row(UNIT_LOGIC, OP_BUF1, 1, 2, 0, 3, 1, 0, MODE_RAND));
		rows.push_back(make_row(UNIT_LOGIC, OP_AND, 3, 4, 0, 5, 1, 0, MODE_RAND));
		rows.push_back(make_row(UNIT_LOGIC, OP_OR, 3, 5, 0, 6, 1, 0, MODE_RAND));
		rows.push_back(make_row(UNIT_LOGIC, OP_XOR, 6, 5, 0, 7, 1, 0, MODE_RAND));
		rows.push_back(make_row(UNIT_LOGIC, OP_NOT, 7, 0, 0, 8, 1, 1, MODE_RAND));
		// Immediate source1 names the last destination
		rows.push_back(make_row(UNIT_SHIFT, OP_SLL, 8, 8, 1, 9, 1, 1, MODE_RAND));
		rows.push_back(make_row(UNIT_SHIFT, OP_SRL, 9, 8, 0, 10, 1, 1, MODE_RAND));
		rows.push_back(make_row(UNIT_SHIFT, OP_SRA, 10, 11, 0, 11, 1, 1, MODE_RAND));
		rows.push_back(make_row(UNIT_SHIFT, OP_ROL, 11, 12, 0, 12, 1, 1, MODE_RAND));
		rows.push_back(make_row(UNIT_SHIFT, OP_ROR, 12, 13, 0, 13, 0, 1, MODE_RAND));
		rows.push_back(make_row(UNIT_ADDER, OP_ADD, 13, 14, 0, 14, 1, 1, MODE_RAND));
		rows.push_back(make_row(UNIT_ADDER, OP_SUB, 14, 14, 0, 15, 1, 1, MODE_SAME));
		rows.push_back(make_row(UNIT_ADDER, OP_SUB, 20, 21, 0, 16, 1, 1, MODE_RAND));
		rows.push_back(make_row(UNIT_ADDER, OP_ADD, 20, 21, 0, 17, 1, 0, MODE_RAND));
		rows.push_back(make_row(UNIT_MUL, OP_MULL, 16, 17, 0, 18, 1, 1, MODE_RAND));
		rows.push_back(make_row(UNIT_MUL, OP_MULH, 18, 17, 0, 19, 1, 1, MODE_RAND));
		rows.push_back(make_row(UNIT_MUL, OP_MULL, 22, 23, 0, 20, 1, 0, MODE_RAND));
		rows.push_back(make_row(UNIT_SHIFT, OP_SLL, 24, 25, 1, 21, 1, 1, MODE_ZERO));
		rows.push_back(make_row(UNIT_DIV, OP_UDIV, 15, 16, 0, 24, 1, 0, MODE_RAND));
		rows.push_back(make_row(UNIT_DIV, OP_UMOD, 1, 2, 0, 24, 1, 1, MODE_RAND));
		rows.push_back(make_row(UNIT_DIV, OP_SDIV, 24, 3, 0, 25, 1, 0, MODE_RAND));
		rows.push_back(make_row(UNIT_DIV, OP_SMOD, 25, 4, 0, 26, 1, 0, MODE_RAND));
		rows.push_back(make_row(UNIT_DIV, OP_SDIV, 1, 2, 0, 26, 1, 0, MODE_ZERO));
		rows.push_back(make_row(UNIT_DIV, OP_UMOD, 26, 2, 0, 27, 1, 0, MODE_ZERO));
		rows.push_back(make_row(UNIT_LOGIC, OP_OR, 27, 26, 0, 3, 1, 0, MODE_RAND));
	endtask

endmodule

// File: exec_stage.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module exec_stage (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic stall,
	input logic prev_valid,
	output logic prev_lock,
	input exec_pkg::exec_unit_t prev_unit,
	input exec_pkg::exec_cmd_u prev_cmd,
	input logic [`EXEC_PTR_W-1:0] prev_destination,
	input logic prev_writeback,
	input logic prev_flags_writeback,
	input logic [`EXEC_DATA_W-1:0] prev_source0,
	input logic [`EXEC_DATA_W-1:0] prev_source1,
	input logic [`EXEC_PTR_W-1:0] prev_source0_pointer,
	input logic [`EXEC_PTR_W-1:0] prev_source1_pointer,
	input logic prev_source1_imm,
	output logic mem_req,
	input logic mem_busy,
	output logic mem_rw,
	output exec_pkg::exec_order_t mem_order,
	output logic [`EXEC_DATA_W-1:0] mem_addr,
	output logic [`EXEC_DATA_W-1:0] mem_wdata,
	input logic mem_ack,
	input logic [`EXEC_DATA_W-1:0] mem_rdata,
	output logic next_valid,
	output logic [`EXEC_DATA_W-1:0] next_data,
	output logic [`EXEC_PTR_W-1:0] next_destination,
	output logic next_writeback,
	output exec_pkg::exec_flags_t flags
);
	import exec_pkg::*;

	logic [`EXEC_DATA_W-1:0] source0;
	logic [`EXEC_DATA_W-1:0] source1;
	logic [`EXEC_DATA_W-1:0] alu_data;
	exec_flags_t alu_flags;
	logic div_start;
	logic div_signed;
	logic div_done;
	logic [`EXEC_DATA_W-1:0] div_quotient;
	logic [`EXEC_DATA_W-1:0] div_remainder;

	exec_result_if result_bus ();

	operand_forward u_forward (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.result(result_bus.fwd_mp),
		.prev_source0(prev_source0),
		.prev_source1(prev_source1),
		.prev_source0_pointer(prev_source0_pointer),
		.prev_source1_pointer(prev_source1_pointer),
		.prev_source1_imm(prev_source1_imm),
		.source0(source0),
		.source1(source1)
	);

	alu_unit u_alu (
		.unit(prev_unit),
		.cmd(prev_cmd),
		.source0(source0),
		.source1(source1),
		.data(alu_data),
		.flags(alu_flags)
	);

	serial_divider u_div (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.abort(flush),
		.start(div_start),
		.signed_op(div_signed),
		.dividend(source0),
		.divisor(source1),
		.done(div_done),
		.quotient(div_quotient),
		.remainder(div_remainder)
	);

	exec_control u_ctrl (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.stall(stall),
		.prev_valid(prev_valid),
		.prev_lock(prev_lock),
		.prev_unit(prev_unit),
		.prev_cmd(prev_cmd),
		.prev_destination(prev_destination),
		.prev_writeback(prev_writeback),
		.prev_flags_writeback(prev_flags_writeback),
		.source0(source0),
		.source1(source1),
		.alu_data(alu_data),
		.alu_flags(alu_flags),
		.div_start(div_start),
		.div_signed(div_signed),
		.div_done(div_done),
		.div_quotient(div_quotient),
		.div_remainder(div_remainder),
		.mem_req(mem_req),
		.mem_busy(mem_busy),
		.mem_rw(mem_rw),
		.mem_order(mem_order),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.result(result_bus.ctrl_mp),
		.next_valid(next_valid),
		.flags(flags)
	);

	assign next_data = result_bus.data;
	assign next_destination = result_bus.destination;
	assign next_writeback = result_bus.writeback;

endmodule

// File: exec_control.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module exec_control (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic stall,
	input logic prev_valid,
	output logic prev_lock,
	input exec_pkg::exec_unit_t prev_unit,
	input exec_pkg::exec_cmd_u prev_cmd,
	input logic [`EXEC_PTR_W-1:0] prev_destination,
	input logic prev_writeback,
	input logic prev_flags_writeback,
	input logic [`EXEC_DATA_W-1:0] source0,
	input logic [`EXEC_DATA_W-1:0] source1,
	input logic [`EXEC_DATA_W-1:0] alu_data,
	input exec_pkg::exec_flags_t alu_flags,
	output logic div_start,
	output logic div_signed,
	input logic div_done,
	input logic [`EXEC_DATA_W-1:0] div_quotient,
	input logic [`EXEC_DATA_W-1:0] div_remainder,
	output logic mem_req,
	input logic mem_busy,
	output logic mem_rw,
	output exec_pkg::exec_order_t mem_order,
	output logic [`EXEC_DATA_W-1:0] mem_addr,
	output logic [`EXEC_DATA_W-1:0] mem_wdata,
	input logic mem_ack,
	input logic [`EXEC_DATA_W-1:0] mem_rdata,
	exec_result_if.ctrl_mp result,
	output logic next_valid,
	output exec_pkg::exec_flags_t flags
);
	import exec_pkg::*;

	localparam int W = `EXEC_DATA_W;
	localparam int OFF_W = $clog2(`EXEC_BYTES);
	localparam logic [1:0] ST_NORMAL = 2'd0;
	localparam logic [1:0] ST_DIV_WAIT = 2'd1;
	localparam logic [1:0] ST_LOAD = 2'd2;
	localparam logic [1:0] ST_STORE = 2'd3;

	logic [1:0] state;
	logic accept;
	logic one_cycle;
	logic flag_unit;
	logic [OFF_W-1:0] offset;
	logic b_valid;
	logic b_req;
	logic b_div_rem;
	logic [OFF_W-1:0] b_offset;
	exec_order_t b_order;
	logic [W-1:0] b_addr;
	logic [W-1:0] b_wdata;
	logic [W-1:0] b_data;
	logic [`EXEC_PTR_W-1:0] b_destination;
	logic b_writeback;
	logic [W-1:0] load_shifted;
	logic [W-1:0] load_data;

	assign prev_lock = (state != ST_NORMAL);
	assign accept = prev_valid && !prev_lock && !stall;
	assign one_cycle = prev_unit inside {UNIT_LOGIC, UNIT_SHIFT, UNIT_ADDER, UNIT_MUL};
	assign flag_unit = prev_unit inside {UNIT_SHIFT, UNIT_ADDER, UNIT_MUL};
	assign offset = source1[OFF_W-1:0];

	assign div_start = accept && (prev_unit == UNIT_DIV);
	assign div_signed = prev_cmd.op inside {OP_SDIV, OP_SMOD};

	// Bring the addressed lane down to bit 0, then trim to the access size
	assign load_shifted = mem_rdata >> {b_offset, 3'b000};
	always_comb begin
		case (b_order)
			ORDER_BYTE: load_data = {{(W-8){1'b0}}, load_shifted[7:0]};
			ORDER_HALF: load_data = {{(W-16){1'b0}}, load_shifted[15:0]};
			default: load_data = load_shifted;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_NORMAL;
			b_valid <= 1'b0;
			b_req <= 1'b0;
		end else if (flush) begin
			state <= ST_NORMAL;
			b_valid <= 1'b0;
			b_req <= 1'b0;
		end else begin
			case (state)
				ST_NORMAL: begin
					b_valid <= accept && one_cycle;
					if (accept && prev_unit == UNIT_DIV) begin
						state <= ST_DIV_WAIT;
					end else if (accept && prev_unit == UNIT_LDST) begin
						b_req <= 1'b1;
						state <= prev_cmd.mem.rw ? ST_STORE : ST_LOAD;
					end
				end
				ST_DIV_WAIT: begin
					b_valid <= div_done;
					if (div_done) begin
						state <= ST_NORMAL;
					end
				end
				default: begin
					// Request drops once seen without busy
					b_req <= b_req && mem_busy && !mem_ack;
					b_valid <= mem_ack && (state == ST_LOAD);
					if (mem_ack) begin
						state <= ST_NORMAL;
					end
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			flags <= '0;
		end else if (flush) begin
			flags <= '0;
		end else if (accept && prev_flags_writeback && flag_unit) begin
			flags <= alu_flags;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			b_destination <= prev_destination;
			b_writeback <= prev_writeback;
			b_data <= alu_data;
			b_div_rem <= prev_cmd.op inside {OP_UMOD, OP_SMOD};
			b_offset <= offset;
			b_order <= prev_cmd.mem.order;
			b_addr <= {source1[W-1:OFF_W], {OFF_W{1'b0}}};
			b_wdata <= source0 << {offset, 3'b000};
		end else if (state == ST_DIV_WAIT && div_done) begin
			b_data <= b_div_rem ? div_remainder : div_quotient;
		end else if (state == ST_LOAD && mem_ack) begin
			b_data <= load_data;
		end
	end

	assign mem_req = b_req;
	assign mem_rw = (state == ST_STORE);
	assign mem_order = b_order;
	assign mem_addr = b_addr;
	assign mem_wdata = b_wdata;

	assign result.valid = b_valid;
	assign result.data = b_data;
	assign result.destination = b_destination;
	assign result.writeback = b_writeback;
	assign next_valid = b_valid && !stall;

endmodule

// File: serial_divider.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module serial_divider (
	input logic iCLOCK,
	input logic inRESET,
	input logic abort,
	input logic start,
	input logic signed_op,
	input logic [`EXEC_DATA_W-1:0] dividend,
	input logic [`EXEC_DATA_W-1:0] divisor,
	output logic done,
	output logic [`EXEC_DATA_W-1:0] quotient,
	output logic [`EXEC_DATA_W-1:0] remainder
);
	localparam int W = `EXEC_DATA_W;

	logic busy;
	logic [$clog2(W)-1:0] count;
	logic [W-1:0] acc;
	logic [W-1:0] quo;
	logic [W-1:0] dvsr;
	logic neg_q;
	logic neg_r;
	logic [W-1:0] dividend_mag;
	logic [W-1:0] divisor_mag;
	logic [W:0] shifted;
	logic [W:0] trial;
	logic [W-1:0] acc_next;
	logic [W-1:0] quo_next;
	logic zero_div;

	assign dividend_mag = (signed_op && dividend[W-1]) ? -dividend : dividend;
	assign divisor_mag = (signed_op && divisor[W-1]) ? -divisor : divisor;
	assign zero_div = (divisor == '0);

	// Restoring step, a negative trial keeps the old remainder
	assign shifted = {acc, quo[W-1]};
	assign trial = shifted - {1'b0, dvsr};
	assign acc_next = trial[W] ? shifted[W-1:0] : trial[W-1:0];
	assign quo_next = {quo[W-2:0], ~trial[W]};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else if (abort) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (busy) begin
				count <= count - 1'b1;
				if (count == '0) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end else if (start) begin
				if (zero_div) begin
					done <= 1'b1;
				end else begin
					busy <= 1'b1;
					count <= '1;
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (busy) begin
			acc <= acc_next;
			quo <= quo_next;
			if (count == '0) begin
				quotient <= neg_q ? -quo_next : quo_next;
				remainder <= neg_r ? -acc_next : acc_next;
			end
		end else if (start) begin
			acc <= '0;
			quo <= dividend_mag;
			dvsr <= divisor_mag;
			neg_q <= signed_op && (dividend[W-1] ^ divisor[W-1]);
			neg_r <= signed_op && dividend[W-1];
			// Zero divisor result, replaced at the end otherwise
			quotient <= '1;
			remainder <= dividend;
		end
	end

endmodule

// File: alu_unit.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module alu_unit (
	input exec_pkg::exec_unit_t unit,
	input exec_pkg::exec_cmd_u cmd,
	input logic [`EXEC_DATA_W-1:0] source0,
	input logic [`EXEC_DATA_W-1:0] source1,
	output logic [`EXEC_DATA_W-1:0] data,
	output exec_pkg::exec_flags_t flags
);
	import exec_pkg::*;

	localparam int W = `EXEC_DATA_W;
	localparam int SHAMT_W = $clog2(W);

	logic [SHAMT_W-1:0] shamt;
	logic [W:0] sll_ext;
	logic [W:0] srl_ext;
	logic [W:0] sra_ext;
	logic [2*W-1:0] rol_ext;
	logic [2*W-1:0] ror_ext;
	logic [W:0] add_ext;
	logic [W:0] sub_ext;
	logic [2*W-1:0] product;
	logic carry;
	logic overflow;
	logic [`EXEC_FLAG_W-1:0] flag_bits;

	assign shamt = source1[SHAMT_W-1:0];

	// Extra bit catches the last bit shifted out
	assign sll_ext = {1'b0, source0} << shamt;
	assign srl_ext = {source0, 1'b0} >> shamt;
	assign sra_ext = $signed({source0, 1'b0}) >>> shamt;
	assign rol_ext = {source0, source0} << shamt;
	assign ror_ext = {source0, source0} >> shamt;

	// Bit W of the difference is the borrow
	assign add_ext = {1'b0, source0} + {1'b0, source1};
	assign sub_ext = {1'b0, source0} - {1'b0, source1};
	assign product = source0 * source1;

	always_comb begin
		data = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (unit)
			UNIT_LOGIC: begin
				case (cmd.op)
					OP_BUF1: data = source1;
					OP_AND: data = source0 & source1;
					OP_OR: data = source0 | source1;
					OP_XOR: data = source0 ^ source1;
					OP_NOT: data = ~source0;
					default: data = '0;
				endcase
			end
			UNIT_SHIFT: begin
				case (cmd.op)
					OP_SLL: begin
						data = sll_ext[W-1:0];
						carry = sll_ext[W];
					end
					OP_SRL: begin
						data = srl_ext[W:1];
						carry = srl_ext[0];
					end
					OP_SRA: begin
						data = sra_ext[W:1];
						carry = sra_ext[0];
					end
					OP_ROL: begin
						data = rol_ext[2*W-1:W];
						carry = (shamt != '0) && data[0];
					end
					OP_ROR: begin
						data = ror_ext[W-1:0];
						carry = (shamt != '0) && data[W-1];
					end
					default: data = source0;
				endcase
			end
			UNIT_ADDER: begin
				if (cmd.op == OP_SUB) begin
					data = sub_ext[W-1:0];
					carry = sub_ext[W];
					overflow = (source0[W-1] != source1[W-1]) && (data[W-1] != source0[W-1]);
				end else begin
					data = add_ext[W-1:0];
					carry = add_ext[W];
					overflow = (source0[W-1] == source1[W-1]) && (data[W-1] != source0[W-1]);
				end
			end
			UNIT_MUL: begin
				if (cmd.op == OP_MULH) begin
					data = product[2*W-1:W];
				end else begin
					data = product[W-1:0];
					carry = product[W];
					overflow = product[W-1] ^ product[W];
				end
			end
			default: data = '0;
		endcase
	end

	// Order matches sf, of, cf, pf, zf
	assign flag_bits = {data[W-1], overflow, carry, data[0], ~|data};
	assign flags = flag_bits;

endmodule

// File: operand_forward.sv
`timescale 1ns/10ps
`include "exec_config.svh"

module operand_forward (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	exec_result_if.fwd_mp result,
	input logic [`EXEC_DATA_W-1:0] prev_source0,
	input logic [`EXEC_DATA_W-1:0] prev_source1,
	input logic [`EXEC_PTR_W-1:0] prev_source0_pointer,
	input logic [`EXEC_PTR_W-1:0] prev_source1_pointer,
	input logic prev_source1_imm,
	output logic [`EXEC_DATA_W-1:0] source0,
	output logic [`EXEC_DATA_W-1:0] source1
);
	logic hist_valid;
	logic [`EXEC_DATA_W-1:0] hist_data;
	logic [`EXEC_PTR_W-1:0] hist_destination;
	logic hist_writeback;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			hist_valid <= 1'b0;
		end else if (flush) begin
			hist_valid <= 1'b0;
		end else if (result.valid) begin
			hist_valid <= 1'b1;
		end
	end

	// History follows the result register
	always_ff @(posedge iCLOCK) begin
		if (result.valid) begin
			hist_data <= result.data;
			hist_destination <= result.destination;
			hist_writeback <= result.writeback;
		end
	end

	// Newest result first, then history, then the supplied value
	function automatic logic [`EXEC_DATA_W-1:0] resolve(
		input logic [`EXEC_PTR_W-1:0] pointer,
		input logic [`EXEC_DATA_W-1:0] supplied
	);
		if (result.valid && result.writeback && result.destination == pointer) begin
			return result.data;
		end else if (hist_valid && hist_writeback && hist_destination == pointer) begin
			return hist_data;
		end
		return supplied;
	endfunction

	always_comb begin
		source0 = resolve(prev_source0_pointer, prev_source0);
		source1 = prev_source1_imm ? prev_source1 : resolve(prev_source1_pointer, prev_source1);
	end

endmodule

// File: exec_result_if.sv
`timescale 1ns/10ps
`include "exec_config.svh"

interface exec_result_if;
	logic valid;
	logic [`EXEC_DATA_W-1:0] data;
	logic [`EXEC_PTR_W-1:0] destination;
	logic writeback;

	// Result register owner
	modport ctrl_mp (
		output valid,
		output data,
		output destination,
		output writeback
	);

	// Bypass network
	modport fwd_mp (
		input valid,
		input data,
		input destination,
		input writeback
	);
endinterface

// File: exec_pkg.sv
package exec_pkg;

	typedef enum logic [2:0] {
		UNIT_LOGIC,
		UNIT_SHIFT,
		UNIT_ADDER,
		UNIT_MUL,
		UNIT_DIV,
		UNIT_LDST
	} exec_unit_t;

	typedef enum logic [4:0] {
		OP_BUF1, OP_AND, OP_OR, OP_XOR, OP_NOT,
		OP_SLL, OP_SRL, OP_SRA, OP_ROL, OP_ROR,
		OP_ADD, OP_SUB,
		OP_MULL, OP_MULH,
		OP_UDIV, OP_UMOD, OP_SDIV, OP_SMOD
	} alu_op_t;

	typedef enum logic [1:0] {
		ORDER_BYTE = 2'd0,
		ORDER_HALF = 2'd1,
		ORDER_WORD = 2'd2
	} exec_order_t;

	// Load/store reads the mem view, every other unit the op view
	typedef union packed {
		alu_op_t op;
		struct packed {
			logic rw;
			exec_order_t order;
			logic [1:0] spare;
		} mem;
	} exec_cmd_u;

	typedef struct packed {
		logic sf;
		logic of;
		logic cf;
		logic pf;
		logic zf;
	} exec_flags_t;

endpackage

// File: exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath word width
`define EXEC_DATA_W 32

// General register pointer
`define EXEC_PTR_W 5

// One bit per flag in the flags register
`define EXEC_FLAG_W 5

// Byte lanes per data word
`define EXEC_BYTES 4

`endif
